/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_debug_subsystem
DUT_TOP   := debug_subsystem
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/dbg_defs.svh */
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// JTAG transport

// Version 1, part 0x0db1, manufacturer 0, LSB always one
`define DBG_IDCODE          32'h10db_1001
`define DBG_IR_LEN          5

//////////////////////////////////////////////////////////////////////
// Debug module interface

`define DBG_DMI_ABITS       7
`define DBG_DMI_DATAW       32
`define DBG_DMI_LEN         41          // addr + data + op

`define DBG_IDLE_HINT       3'd1        // Cycles to spend in Run-Test-Idle
`define DBG_DTM_VERSION     4'd1        // Spec 0.13
`define DBG_DM_VERSION      4'd2        // Spec 0.13

//////////////////////////////////////////////////////////////////////
// Debug module register map

`define DBG_ADDR_DATA0      7'h04
`define DBG_ADDR_DATA1      7'h05
`define DBG_ADDR_DMCONTROL  7'h10
`define DBG_ADDR_DMSTATUS   7'h11

`endif

/* common/dbg_pkg.sv */
package dbg_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_TEST_LOGIC_RESET,
        TAP_RUN_TEST_IDLE,
        TAP_SELECT_DR_SCAN,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR_SCAN,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_e;

    typedef enum logic [4:0] {
        IR_IDCODE = 5'h01,
        IR_DTMCS  = 5'h10,
        IR_DMI    = 5'h11,
        IR_BYPASS = 5'h1f
    } jtag_ir_e;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    // Status returned in the op field
    typedef enum logic [1:0] {
        DMI_OK     = 2'd0,
        DMI_FAILED = 2'd2,
        DMI_BUSY   = 2'd3              // Never raised, no back-pressure
    } dmi_stat_e;

endpackage

/* design/debug_module.sv */
`timescale 1ns/1ps
`include "dbg_defs.svh"

module debug_module (
    input  logic                       jtag_tck_i,
    input  logic                       rst_n_i,
    input  logic                       dmi_req_i,
    input  dbg_pkg::dmi_op_e           dmi_op_i,
    input  logic [`DBG_DMI_ABITS-1:0]  dmi_addr_i,
    input  logic [`DBG_DMI_DATAW-1:0]  dmi_wdata_i,
    input  logic                       hart_halted_i,
    output logic                       dmi_ack_o,
    output logic [`DBG_DMI_DATAW-1:0]  dmi_rdata_o,
    output logic                       dmi_err_o,
    output logic                       debug_req_o,
    output logic                       ndmreset_o
);

    import dbg_pkg::*;

    logic [`DBG_DMI_DATAW-1:0]  data0_q;
    logic [`DBG_DMI_DATAW-1:0]  data1_q;
    logic                       dmactive_q;
    logic                       ndmreset_q;
    logic                       haltreq_q;
    logic [31:0]                dmcontrol;
    logic [31:0]                dmstatus;
    logic [`DBG_DMI_DATAW-1:0]  rd_data;
    logic                       addr_ok;
    logic                       wr_en;
    logic                       access_err;

    //////////////////////////////////////////////////////////////////////
    // Register views

    assign dmcontrol = {haltreq_q, 29'b0, ndmreset_q, dmactive_q};

    assign dmstatus = {20'b0,
                       ~hart_halted_i,          // allrunning
                       ~hart_halted_i,          // anyrunning
                       hart_halted_i,           // allhalted
                       hart_halted_i,           // anyhalted
                       1'b1,                    // authenticated
                       3'b0,
                       `DBG_DM_VERSION};

    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (dmi_addr_i)
            `DBG_ADDR_DATA0:     rd_data = data0_q;
            `DBG_ADDR_DATA1:     rd_data = data1_q;
            `DBG_ADDR_DMCONTROL: rd_data = dmcontrol;
            `DBG_ADDR_DMSTATUS:  rd_data = dmstatus;
            default:             addr_ok = 1'b0;
        endcase
    end

    assign wr_en      = dmi_req_i && (dmi_op_i == DMI_WRITE);
    assign access_err = !addr_ok || (wr_en && dmi_addr_i == `DBG_ADDR_DMSTATUS);

    //////////////////////////////////////////////////////////////////////
    // Register writes

    always_ff @(posedge jtag_tck_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data0_q    <= '0;
            data1_q    <= '0;
            dmactive_q <= 1'b0;
            ndmreset_q <= 1'b0;
            haltreq_q  <= 1'b0;
        end else begin
            // Inactive module keeps everything cleared
            if (!dmactive_q) begin
                data0_q    <= '0;
                data1_q    <= '0;
                ndmreset_q <= 1'b0;
                haltreq_q  <= 1'b0;
            end
            if (wr_en && !access_err) begin
                case (dmi_addr_i)
                    `DBG_ADDR_DATA0: begin
                        if (dmactive_q) data0_q <= dmi_wdata_i;
                    end
                    `DBG_ADDR_DATA1: begin
                        if (dmactive_q) data1_q <= dmi_wdata_i;
                    end
                    `DBG_ADDR_DMCONTROL: begin
                        dmactive_q <= dmi_wdata_i[0];
                        ndmreset_q <= dmi_wdata_i[0] & dmi_wdata_i[1];
                        haltreq_q  <= dmi_wdata_i[0] & dmi_wdata_i[31];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response, one cycle after the request

    always_ff @(posedge jtag_tck_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dmi_ack_o <= 1'b0;
            dmi_err_o <= 1'b0;
        end else begin
            dmi_ack_o <= dmi_req_i;
            dmi_err_o <= dmi_req_i && access_err;
        end
    end

    always_ff @(posedge jtag_tck_i) begin
        if (dmi_req_i) begin
            dmi_rdata_o <= (dmi_op_i == DMI_READ) ? rd_data : '0;   // Writes return zero
        end
    end

    assign debug_req_o = haltreq_q;
    assign ndmreset_o  = ndmreset_q;

endmodule

/* design/debug_subsystem.sv */
`timescale 1ns/1ps
`include "dbg_defs.svh"

module debug_subsystem (
    input  logic  jtag_tck_i,
    input  logic  rst_n_i,
    input  logic  jtag_tms_i,
    input  logic  jtag_tdi_i,
    input  logic  hart_halted_i,
    output logic  jtag_tdo_o,
    output logic  debug_req_o,
    output logic  ndmreset_o
);

    import dbg_pkg::*;

    jtag_ir_e                   ir;
    logic                       capture_dr;
    logic                       shift_dr;
    logic                       update_dr;
    logic                       dr_tdo;

    // DMI between transport and debug module
    logic                       dmi_req;
    dmi_op_e                    dmi_op;
    logic [`DBG_DMI_ABITS-1:0]  dmi_addr;
    logic [`DBG_DMI_DATAW-1:0]  dmi_wdata;
    logic                       dmi_ack;
    logic [`DBG_DMI_DATAW-1:0]  dmi_rdata;
    logic                       dmi_err;

    jtag_tap_ctrl i_tap (
        .jtag_tck_i   (jtag_tck_i),
        .rst_n_i      (rst_n_i),
        .tms_i        (jtag_tms_i),
        .tdi_i        (jtag_tdi_i),
        .dr_tdo_i     (dr_tdo),
        .ir_o         (ir),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .tdo_o        (jtag_tdo_o)
    );

    dtm_regs i_dtm (
        .jtag_tck_i   (jtag_tck_i),
        .rst_n_i      (rst_n_i),
        .tdi_i        (jtag_tdi_i),
        .ir_i         (ir),
        .capture_dr_i (capture_dr),
        .shift_dr_i   (shift_dr),
        .update_dr_i  (update_dr),
        .dmi_ack_i    (dmi_ack),
        .dmi_rdata_i  (dmi_rdata),
        .dmi_err_i    (dmi_err),
        .dr_tdo_o     (dr_tdo),
        .dmi_req_o    (dmi_req),
        .dmi_op_o     (dmi_op),
        .dmi_addr_o   (dmi_addr),
        .dmi_wdata_o  (dmi_wdata)
    );

    debug_module i_dm (
        .jtag_tck_i    (jtag_tck_i),
        .rst_n_i       (rst_n_i),
        .dmi_req_i     (dmi_req),
        .dmi_op_i      (dmi_op),
        .dmi_addr_i    (dmi_addr),
        .dmi_wdata_i   (dmi_wdata),
        .hart_halted_i (hart_halted_i),
        .dmi_ack_o     (dmi_ack),
        .dmi_rdata_o   (dmi_rdata),
        .dmi_err_o     (dmi_err),
        .debug_req_o   (debug_req_o),
        .ndmreset_o    (ndmreset_o)
    );

endmodule

/* design/dtm/dtm_regs.sv */
`timescale 1ns/1ps
`include "dbg_defs.svh"

module dtm_regs (
    input  logic                       jtag_tck_i,
    input  logic                       rst_n_i,
    input  logic                       tdi_i,
    input  dbg_pkg::jtag_ir_e          ir_i,
    input  logic                       capture_dr_i,
    input  logic                       shift_dr_i,
    input  logic                       update_dr_i,
    input  logic                       dmi_ack_i,
    input  logic [`DBG_DMI_DATAW-1:0]  dmi_rdata_i,
    input  logic                       dmi_err_i,
    output logic                       dr_tdo_o,
    output logic                       dmi_req_o,
    output dbg_pkg::dmi_op_e           dmi_op_o,
    output logic [`DBG_DMI_ABITS-1:0]  dmi_addr_o,
    output logic [`DBG_DMI_DATAW-1:0]  dmi_wdata_o
);

    import dbg_pkg::*;

    logic [`DBG_DMI_LEN-1:0]    dr_q;           // Shared by all data registers
    logic [`DBG_DMI_LEN-1:0]    capture_val;
    logic [31:0]                dtmcs;
    logic [`DBG_DMI_ABITS-1:0]  last_addr_q;
    logic [`DBG_DMI_DATAW-1:0]  last_rdata_q;
    dmi_stat_e                  stat_q;
    logic                       op_valid;
    logic                       dmireset;

    //////////////////////////////////////////////////////////////////////
    // Capture and shift

    assign dtmcs = {17'b0,
                    `DBG_IDLE_HINT,             // 14:12
                    stat_q,                     // 11:10 dmistat
                    6'(`DBG_DMI_ABITS),         // 9:4
                    `DBG_DTM_VERSION};          // 3:0

    always_comb begin
        case (ir_i)
            IR_IDCODE: capture_val = `DBG_DMI_LEN'(`DBG_IDCODE);
            IR_DTMCS:  capture_val = `DBG_DMI_LEN'(dtmcs);
            IR_DMI:    capture_val = {last_addr_q, last_rdata_q, stat_q};
            default:   capture_val = '0;        // BYPASS shifts out a 0 first
        endcase
    end

    // Length of the active register follows the IR
    always_ff @(posedge jtag_tck_i) begin
        if (capture_dr_i) begin
            dr_q <= capture_val;
        end else if (shift_dr_i) begin
            case (ir_i)
                IR_DMI: begin
                    dr_q <= {tdi_i, dr_q[`DBG_DMI_LEN-1:1]};
                end
                IR_IDCODE, IR_DTMCS: begin
                    dr_q[31:0] <= {tdi_i, dr_q[31:1]};
                end
                default: begin
                    dr_q[0] <= tdi_i;
                end
            endcase
        end
    end

    assign dr_tdo_o = dr_q[0];

    //////////////////////////////////////////////////////////////////////
    // DMI request

    // DMI layout: address on top, data in the middle, op in 1:0
    assign dmi_op_o    = dmi_op_e'(dr_q[1:0]);
    assign dmi_wdata_o = dr_q[`DBG_DMI_DATAW+1:2];
    assign dmi_addr_o  = dr_q[`DBG_DMI_LEN-1 -: `DBG_DMI_ABITS];

    assign op_valid = (dmi_op_o == DMI_READ) || (dmi_op_o == DMI_WRITE);

    // Dropped while an earlier error is still sticky
    assign dmi_req_o = update_dr_i && (ir_i == IR_DMI) && op_valid && (stat_q == DMI_OK);

    // DTMCS bit 16 clears the sticky status
    assign dmireset = update_dr_i && (ir_i == IR_DTMCS) && dr_q[16];

    //////////////////////////////////////////////////////////////////////
    // Result and sticky status

    always_ff @(posedge jtag_tck_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stat_q       <= DMI_OK;
            last_addr_q  <= '0;
            last_rdata_q <= '0;
        end else begin
            if (dmi_req_o) begin
                last_addr_q <= dmi_addr_o;
            end
            if (dmi_ack_i) begin
                last_rdata_q <= dmi_rdata_i;
                if (dmi_err_i) begin
                    stat_q <= DMI_FAILED;
                end
            end
            if (dmireset) begin
                stat_q <= DMI_OK;
            end
        end
    end

endmodule

/* design/jtag_tap/jtag_tap_ctrl.sv */
`timescale 1ns/1ps
`include "dbg_defs.svh"

module jtag_tap_ctrl (
    input  logic               jtag_tck_i,
    input  logic               rst_n_i,
    input  logic               tms_i,
    input  logic               tdi_i,
    input  logic               dr_tdo_i,
    output dbg_pkg::jtag_ir_e  ir_o,
    output logic               capture_dr_o,
    output logic               shift_dr_o,
    output logic               update_dr_o,
    output logic               tdo_o
);

    import dbg_pkg::*;

    tap_state_e             state_q;
    tap_state_e             state_d;
    logic [`DBG_IR_LEN-1:0] ir_shift_q;
    jtag_ir_e               ir_q;

    //////////////////////////////////////////////////////////////////////
    // Controller FSM

    always_comb begin
        case (state_q)
            TAP_TEST_LOGIC_RESET: state_d = tms_i ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR_SCAN:   state_d = tms_i ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR_SCAN:   state_d = tms_i ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            default:              state_d = TAP_TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge jtag_tck_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TAP_TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction register

    // Capture pattern ends in 01 as 1149.1 requires
    always_ff @(posedge jtag_tck_i) begin
        if (state_q == TAP_CAPTURE_IR) begin
            ir_shift_q <= `DBG_IR_LEN'(1);
        end else if (state_q == TAP_SHIFT_IR) begin
            ir_shift_q <= {tdi_i, ir_shift_q[`DBG_IR_LEN-1:1]};
        end
    end

    always_ff @(posedge jtag_tck_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ir_q <= IR_IDCODE;
        end else if (state_q == TAP_TEST_LOGIC_RESET) begin
            ir_q <= IR_IDCODE;                      // Reload after TMS reset
        end else if (state_q == TAP_UPDATE_IR) begin
            case (ir_shift_q)
                IR_IDCODE, IR_DTMCS, IR_DMI: ir_q <= jtag_ir_e'(ir_shift_q);
                default:                     ir_q <= IR_BYPASS;
            endcase
        end
    end

    assign ir_o = ir_q;

    // DR strobes, each state lasts one cycle except Shift-DR
    assign capture_dr_o = (state_q == TAP_CAPTURE_DR);
    assign shift_dr_o   = (state_q == TAP_SHIFT_DR);
    assign update_dr_o  = (state_q == TAP_UPDATE_DR);

    // TDO from the current LSB
    always_comb begin
        case (state_q)
            TAP_SHIFT_IR: tdo_o = ir_shift_q[0];
            TAP_SHIFT_DR: tdo_o = dr_tdo_i;
            default:      tdo_o = 1'b0;
        endcase
    end

endmodule

/* sim/tb_jtag_tasks.svh */
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Random bits

// Fibonacci form, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic random_bits(input int n, output logic [40:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits[i] = lfsr_q[0];
        lfsr_q  = lfsr_next(lfsr_q);                // One step per bit
    end
endtask

//////////////////////////////////////////////////////////////////////
// JTAG scans, all starting and ending in Run-Test-Idle

// TDO only moves on the rising edge, so it is read before new TMS/TDI
task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
    @(negedge tck);
    tdo_v = tdo;
    tms   = tms_v;
    tdi   = tdi_v;
endtask

task automatic reset_tap();
    logic b;
    repeat (5) tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);                       // -> Run-Test-Idle
endtask

task automatic scan_ir(input logic [4:0] code);
    logic [4:0] captured;
    logic       b;
    tck_cycle(1'b1, 1'b0, b);                       // -> Select-DR
    tck_cycle(1'b1, 1'b0, b);                       // -> Select-IR
    tck_cycle(1'b0, 1'b0, b);                       // -> Capture-IR
    tck_cycle(1'b0, 1'b0, b);                       // -> Shift-IR
    for (int i = 0; i < `DBG_IR_LEN; i++) begin
        tck_cycle(i == `DBG_IR_LEN - 1, code[i], b);
        captured[i] = b;
    end
    tck_cycle(1'b1, 1'b0, b);                       // -> Update-IR
    tck_cycle(1'b0, 1'b0, b);
    assert (captured == 5'b00001)
        else report_failure($sformatf("IR capture returned %05b", captured));
endtask

// Last data bit goes out with TMS high, into Exit1-DR
task automatic scan_dr(input int len, input logic [40:0] din, output logic [40:0] dout);
    logic b;
    dout = '0;
    tck_cycle(1'b1, 1'b0, b);                       // -> Select-DR
    tck_cycle(1'b0, 1'b0, b);                       // -> Capture-DR
    tck_cycle(1'b0, 1'b0, b);                       // -> Shift-DR
    for (int i = 0; i < len; i++) begin
        tck_cycle(i == len - 1, din[i], b);
        dout[i] = b;
    end
    tck_cycle(1'b1, 1'b0, b);                       // -> Update-DR
    tck_cycle(1'b0, 1'b0, b);
endtask

// Request scan, then a NOP scan whose capture holds the result
task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr,
                          input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic [1:0] stat);
    logic [40:0] dout;
    scan_ir(IR_DMI);
    scan_dr(`DBG_DMI_LEN, {addr, wdata, op}, dout);
    scan_dr(`DBG_DMI_LEN, '0, dout);
    rdata = dout[33:2];
    stat  = dout[1:0];
endtask

`endif

/* sim/tb_debug_subsystem.sv */
`timescale 1ns/1ps
`include "dbg_defs.svh"

module tb_debug_subsystem;

    import dbg_pkg::*;

    logic        tck;
    logic        rst_n;
    logic        tms;
    logic        tdi;
    logic        hart_halted = 1'b0;
    logic        tdo;
    logic        debug_req;
    logic        ndmreset;
    logic [15:0] lfsr_q = 16'd30;

    debug_subsystem i_dut (
        .jtag_tck_i    (tck),
        .rst_n_i       (rst_n),
        .jtag_tms_i    (tms),
        .jtag_tdi_i    (tdi),
        .hart_halted_i (hart_halted),
        .jtag_tdo_o    (tdo),
        .debug_req_o   (debug_req),
        .ndmreset_o    (ndmreset)
    );

    initial begin
        tck = 1'b0;
        forever #4 tck = ~tck;
    end

    // Hart stub stays halted while the request is up
    always @(negedge tck) begin
        hart_halted <= rst_n && debug_req;
    end

    task automatic report_failure(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Testbench failed");
        $fatal(1, "stopped on timeout");
    endtask

    `include "tb_jtag_tasks.svh"

    // Every DMI request is answered on the next cycle
    a_dmi_ack: assert property (@(posedge tck) disable iff (!rst_n)
        i_dut.dmi_req |=> i_dut.dmi_ack)
        else report_failure("DMI request without acknowledge one cycle later");

    function automatic logic [31:0] dmstatus_for(input logic halted);
        logic [31:0] v;
        v     = 32'(`DBG_DM_VERSION);
        v[7]  = 1'b1;
        v[8]  = halted;
        v[9]  = halted;
        v[10] = !halted;
        v[11] = !halted;
        return v;
    endfunction

    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic [1:0]  stat;
        dmi_access(DMI_WRITE, addr, data, rdata, stat);
        assert (stat == DMI_OK)
            else report_failure($sformatf("write to 0x%02h gave status %0d", addr, stat));
    endtask

    task automatic check_read(input logic [6:0] addr, input logic [31:0] exp,
                              input logic [1:0] exp_stat);
        logic [31:0] rdata;
        logic [1:0]  stat;
        dmi_access(DMI_READ, addr, 32'h0, rdata, stat);
        assert (stat == exp_stat)
            else report_failure($sformatf("read of 0x%02h gave status %0d", addr, stat));
        if (exp_stat == DMI_OK) begin
            assert (rdata == exp)
                else report_failure($sformatf("read of 0x%02h gave 0x%08h, expected 0x%08h",
                                              addr, rdata, exp));
        end
    endtask

    task automatic check_bypass(input logic [4:0] code);
        logic [40:0] din;
        logic [40:0] dout;
        scan_ir(code);
        random_bits(24, din);
        scan_dr(24, din, dout);
        assert (dout[23:0] == {din[22:0], 1'b0})
            else report_failure($sformatf("IR 0x%02h shifted out 0x%06h for 0x%06h",
                                          code, dout[23:0], din[23:0]));
    endtask

    task automatic check_dtmcs(input logic [40:0] din, input logic [1:0] exp_stat);
        logic [40:0] dout;
        scan_ir(IR_DTMCS);
        scan_dr(32, din, dout);
        assert (dout[3:0] == `DBG_DTM_VERSION && dout[9:4] == 6'd7 &&
                dout[14:12] == `DBG_IDLE_HINT && dout[11:10] == exp_stat)
            else report_failure($sformatf("DTMCS read 0x%08h", dout[31:0]));
    endtask

    task automatic wait_outputs(input logic exp_req, input logic exp_ndm);
        int cycles;
        cycles = 0;
        while ((debug_req !== exp_req || ndmreset !== exp_ndm) && cycles < 20) begin
            @(negedge tck);
            cycles++;
        end
        if (debug_req !== exp_req || ndmreset !== exp_ndm) begin
            abort_on_timeout($sformatf("halt request %0b and ndmreset %0b", exp_req, exp_ndm));
        end
    endtask

    initial begin
        logic [40:0] din;
        logic [40:0] dout;
        logic [31:0] rdata;
        logic [31:0] d0;
        logic [1:0]  stat;
        logic        b;
        logic [5:0]  tms_path;
        rst_n = 1'b0;
        tms   = 1'b1;
        tdi   = 1'b0;
        repeat (2) @(negedge tck);
        rst_n = 1'b1;
        assert (!debug_req && !ndmreset && !tdo)
            else report_failure("outputs not low after reset");

        // IDCODE after reset and after a TMS reset out of Pause-IR
        reset_tap();
        scan_dr(32, '0, dout);
        assert (dout[31:0] == `DBG_IDCODE)
            else report_failure($sformatf("IDCODE after reset read 0x%08h", dout[31:0]));
        scan_ir(IR_BYPASS);
        tms_path = 6'b010011;                       // Run-Test-Idle to Pause-IR
        for (int i = 0; i < 6; i++) begin
            tck_cycle(tms_path[i], 1'b0, b);
        end
        reset_tap();
        scan_dr(32, '0, dout);
        assert (dout[31:0] == `DBG_IDCODE)
            else report_failure($sformatf("IDCODE after TMS reset read 0x%08h", dout[31:0]));

        check_bypass(IR_BYPASS);
        check_bypass(5'h0a);                        // Undefined code
        check_dtmcs('0, DMI_OK);

        // Registers ignore writes until dmactive is set
        random_bits(32, din);
        write_reg(`DBG_ADDR_DATA0, din[31:0]);
        check_read(`DBG_ADDR_DATA0, 32'h0, DMI_OK);
        write_reg(`DBG_ADDR_DMCONTROL, 32'h1);
        random_bits(32, din);
        d0 = din[31:0];
        random_bits(32, din);
        write_reg(`DBG_ADDR_DATA0, d0);
        write_reg(`DBG_ADDR_DATA1, din[31:0]);
        check_read(`DBG_ADDR_DATA0, d0, DMI_OK);
        check_read(`DBG_ADDR_DATA1, din[31:0], DMI_OK);
        check_read(`DBG_ADDR_DMSTATUS, dmstatus_for(1'b0), DMI_OK);

        ////////////////////////////////////////////////////////////////////
        // Halt request and ndmreset

        write_reg(`DBG_ADDR_DMCONTROL, 32'h8000_0001);
        wait_outputs(1'b1, 1'b0);
        check_read(`DBG_ADDR_DMSTATUS, dmstatus_for(1'b1), DMI_OK);
        write_reg(`DBG_ADDR_DMCONTROL, 32'h0000_0003);
        wait_outputs(1'b0, 1'b1);
        write_reg(`DBG_ADDR_DMCONTROL, 32'h0000_0001);
        wait_outputs(1'b0, 1'b0);
        write_reg(`DBG_ADDR_DMCONTROL, 32'h8000_0003);
        wait_outputs(1'b1, 1'b1);
        write_reg(`DBG_ADDR_DMCONTROL, 32'h0);      // Drop dmactive
        wait_outputs(1'b0, 1'b0);
        check_read(`DBG_ADDR_DMSTATUS, dmstatus_for(1'b0), DMI_OK);
        check_read(`DBG_ADDR_DATA0, 32'h0, DMI_OK);

        ////////////////////////////////////////////////////////////////////
        // Sticky error and dmireset

        write_reg(`DBG_ADDR_DMCONTROL, 32'h1);
        write_reg(`DBG_ADDR_DATA0, d0);
        check_read(7'h20, 32'h0, DMI_FAILED);
        random_bits(32, din);
        dmi_access(DMI_WRITE, `DBG_ADDR_DATA0, din[31:0], rdata, stat);
        assert (stat == DMI_FAILED)
            else report_failure($sformatf("status %0d while error is sticky", stat));
        check_dtmcs(41'h1_0000, DMI_FAILED);        // Also writes dmireset
        check_dtmcs('0, DMI_OK);
        check_read(`DBG_ADDR_DATA0, d0, DMI_OK);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
+incdir+sim
common/dbg_pkg.sv
design/jtag_tap/jtag_tap_ctrl.sv
design/dtm/dtm_regs.sv
design/debug_module.sv
design/debug_subsystem.sv
sim/tb_debug_subsystem.sv
